/* coverageOutput.sv */
// Coverage output stage
// Sign agreement plus clipped box test for both pixels of the pair,
// result register held under back-pressure
`timescale 1ns/1ps
`default_nettype none

module coverageOutput import gpuRasterPkg::*; (
	input  logic                      i_clk,
	input  logic                      i_rstN,
	input  logic                      i_valid,
	input  logic signed [EDGE_W-1:0]  i_w0L,
	input  logic signed [EDGE_W-1:0]  i_w1L,
	input  logic signed [EDGE_W-1:0]  i_w2L,
	input  logic signed [EDGE_W-1:0]  i_w0R,
	input  logic signed [EDGE_W-1:0]  i_w1R,
	input  logic signed [EDGE_W-1:0]  i_w2R,
	input  logic signed [COORD_W-1:0] i_pairX,
	input  logic signed [COORD_W-1:0] i_pairY,
	input  logic signed [COORD_W-1:0] i_boxMinX,
	input  logic signed [COORD_W-1:0] i_boxMaxX,
	input  logic signed [COORD_W-1:0] i_boxMinY,
	input  logic signed [COORD_W-1:0] i_boxMaxY,
	output logic                      o_stall,
	output logic                      o_resValid,
	output logic                      o_resCovL,
	output logic                      o_resCovR,
	output logic signed [COORD_W-1:0] o_resX,
	output logic signed [COORD_W-1:0] o_resY,
	input  logic                      i_resReady
);

	localparam int MSB = EDGE_W - 1;

	assign o_stall = o_resValid & ~i_resReady;

	wire signed [COORD_W-1:0] pxR = i_pairX + 1'b1;	// Odd pixel

	// Inclusive box bounds
	wire inY = (i_pairY >= i_boxMinY) & (i_pairY <= i_boxMaxY);
	wire inXL = (i_pairX >= i_boxMinX) & (i_pairX <= i_boxMaxX);
	wire inXR = (pxR >= i_boxMinX) & (pxR <= i_boxMaxX);

	// All three signs equal covers either winding
	wire sideL = (i_w0L[MSB] == i_w1L[MSB]) & (i_w1L[MSB] == i_w2L[MSB]);
	wire sideR = (i_w0R[MSB] == i_w1R[MSB]) & (i_w1R[MSB] == i_w2R[MSB]);

	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN)
			o_resValid <= 1'b0;
		else if (!o_stall)
			o_resValid <= i_valid;
	end

	// Payload moves only when the slot is free
	always_ff @(posedge i_clk) begin
		if (!o_stall && i_valid) begin
			o_resCovL <= sideL & inXL & inY;
			o_resCovR <= sideR & inXR & inY;
			o_resX <= i_pairX;
			o_resY <= i_pairY;
		end
	end

endmodule

`default_nettype wire

/* edgeEvaluator.sv */
// Edge evaluator
// Takes a pixel-pair query and registers the three edge functions for
// the even (left) and odd (right) pixel of the pair
`timescale 1ns/1ps
`default_nettype none

module edgeEvaluator import gpuRasterPkg::*; (
	input  logic                      i_clk,
	input  logic                      i_rstN,
	input  logic                      i_setupDone,
	input  logic                      i_qValid,
	output logic                      o_qReady,
	input  logic signed [COORD_W-1:0] i_qX,
	input  logic signed [COORD_W-1:0] i_qY,
	input  logic signed [COORD_W-1:0] i_e,
	input  logic signed [COORD_W-1:0] i_f,
	input  logic signed [COORD_W-1:0] i_nega,
	input  logic signed [COORD_W-1:0] i_b,
	input  logic signed [COORD_W-1:0] i_c,
	input  logic signed [COORD_W-1:0] i_negd,
	input  logic                      i_bias0,
	input  logic                      i_bias1,
	input  logic                      i_bias2,
	input  logic signed [COORD_W-1:0] i_vx0,
	input  logic signed [COORD_W-1:0] i_vy0,
	input  logic signed [COORD_W-1:0] i_vx1,
	input  logic signed [COORD_W-1:0] i_vy1,
	input  logic signed [COORD_W-1:0] i_vx2,
	input  logic signed [COORD_W-1:0] i_vy2,
	input  logic                      i_stall,	// Output holds an unaccepted result
	output logic                      o_valid,
	output logic signed [EDGE_W-1:0]  o_w0L,
	output logic signed [EDGE_W-1:0]  o_w1L,
	output logic signed [EDGE_W-1:0]  o_w2L,
	output logic signed [EDGE_W-1:0]  o_w0R,
	output logic signed [EDGE_W-1:0]  o_w1R,
	output logic signed [EDGE_W-1:0]  o_w2R,
	output logic signed [COORD_W-1:0] o_pairX,
	output logic signed [COORD_W-1:0] o_pairY
);

	logic stageFree;
	logic qFire;

	assign stageFree = ~o_valid | ~i_stall;	// Empty or draining
	assign o_qReady = i_setupDone & stageFree;
	assign qFire = i_qValid & o_qReady;

	wire signed [COORD_W-1:0] pxL = {i_qX[COORD_W-1:1], 1'b0};	// Even pixel of pair

	// Pixel offsets from each vertex, one spare bit
	wire signed [COORD_W:0] dx0 = pxL - i_vx0;
	wire signed [COORD_W:0] dy0 = i_qY - i_vy0;
	wire signed [COORD_W:0] dx1 = pxL - i_vx1;
	wire signed [COORD_W:0] dy1 = i_qY - i_vy1;
	wire signed [COORD_W:0] dx2 = pxL - i_vx2;
	wire signed [COORD_W:0] dy2 = i_qY - i_vy2;

	// Bias is -1 or 0
	wire signed [EDGE_W-1:0] bias0 = {EDGE_W{i_bias0}};
	wire signed [EDGE_W-1:0] bias1 = {EDGE_W{i_bias1}};
	wire signed [EDGE_W-1:0] bias2 = {EDGE_W{i_bias2}};

	wire signed [EDGE_W-1:0] w0L = i_e * dy1 + i_f * dx1 + bias0;
	wire signed [EDGE_W-1:0] w1L = i_nega * dy2 + i_b * dx2 + bias1;
	wire signed [EDGE_W-1:0] w2L = i_c * dy0 + i_negd * dx0 + bias2;

	// One step right adds the x coefficient
	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN)
			o_valid <= 1'b0;
		else if (stageFree)
			o_valid <= qFire;
	end

	always_ff @(posedge i_clk) begin
		if (qFire) begin
			o_w0L <= w0L;
			o_w1L <= w1L;
			o_w2L <= w2L;
			o_w0R <= w0L + i_f;
			o_w1R <= w1L + i_b;
			o_w2R <= w2L + i_negd;
			o_pairX <= pxL;
			o_pairY <= i_qY;
		end
	end

endmodule

`default_nettype wire

/* files.f */
gpuRasterPkg.sv
primitiveLoader.sv
triangleSetup.sv
edgeEvaluator.sv
coverageOutput.sv
triangleRaster.sv
tb_triangleRaster.sv

/* gpuRasterPkg.sv */
// Triangle raster shared definitions
// Coordinate, edge and area widths plus primitive span limits
`default_nettype none

package gpuRasterPkg;

	// --------------------------------------------------
	// Datapath widths
	// --------------------------------------------------
	localparam int COORD_W = 12;	// Signed vertex / pixel coordinate
	localparam int AREA_W = 10;	// Unsigned drawing-area bound
	localparam int DIFF_W = 13;	// Full vertex difference, no wrap
	localparam int EDGE_W = 23;	// Edge function, MSB is sign
	localparam int DET_W = 22;	// Area product

	// --------------------------------------------------
	// Span limits
	// --------------------------------------------------
	// Top bits of a difference that must all match
	localparam int MAX_DX_CHECK_BITS = 3;	// -1024..+1023 horizontal
	localparam int MAX_DY_CHECK_BITS = 4;	// -512..+511 vertical

endpackage

`default_nettype wire

/* primitiveLoader.sv */
// Primitive loader
// Accepts a triangle and its drawing area over valid/ready, holds the
// vertex and bound registers and pulses load for the setup stage
`timescale 1ns/1ps
`default_nettype none

module primitiveLoader import gpuRasterPkg::*; (
	input  logic                      i_clk,
	input  logic                      i_rstN,
	input  logic                      i_primValid,
	output logic                      o_primReady,
	input  logic signed [COORD_W-1:0] i_x0,
	input  logic signed [COORD_W-1:0] i_y0,
	input  logic signed [COORD_W-1:0] i_x1,
	input  logic signed [COORD_W-1:0] i_y1,
	input  logic signed [COORD_W-1:0] i_x2,
	input  logic signed [COORD_W-1:0] i_y2,
	input  logic [AREA_W-1:0]         i_daX0,
	input  logic [AREA_W-1:0]         i_daY0,
	input  logic [AREA_W-1:0]         i_daX1,
	input  logic [AREA_W-1:0]         i_daY1,
	input  logic                      i_pipeBusy,	// Query still in evaluator or output
	output logic                      o_load,
	output logic signed [COORD_W-1:0] o_vx0,
	output logic signed [COORD_W-1:0] o_vy0,
	output logic signed [COORD_W-1:0] o_vx1,
	output logic signed [COORD_W-1:0] o_vy1,
	output logic signed [COORD_W-1:0] o_vx2,
	output logic signed [COORD_W-1:0] o_vy2,
	output logic signed [COORD_W-1:0] o_daX0,
	output logic signed [COORD_W-1:0] o_daY0,
	output logic signed [COORD_W-1:0] o_daX1,
	output logic signed [COORD_W-1:0] o_daY1
);

	localparam int PAD_W = COORD_W - AREA_W;

	logic armed;	// Low out of reset and for one cycle after a transfer
	logic primFire;

	assign o_primReady = armed & ~i_pipeBusy;
	assign primFire = i_primValid & o_primReady;

	// Handshake control
	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			armed <= 1'b0;
			o_load <= 1'b0;
		end else begin
			armed <= ~primFire;
			o_load <= primFire;	// Setup samples on the next edge
		end
	end

	// Primitive registers
	always_ff @(posedge i_clk) begin
		if (primFire) begin
			o_vx0 <= i_x0;
			o_vy0 <= i_y0;
			o_vx1 <= i_x1;
			o_vy1 <= i_y1;
			o_vx2 <= i_x2;
			o_vy2 <= i_y2;
			// Bounds are positive, extend with zeros
			o_daX0 <= {{PAD_W{1'b0}}, i_daX0};
			o_daY0 <= {{PAD_W{1'b0}}, i_daY0};
			o_daX1 <= {{PAD_W{1'b0}}, i_daX1};
			o_daY1 <= {{PAD_W{1'b0}}, i_daY1};
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the triangle raster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_triangleRaster -f files.f -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Build failed, see build.log"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation run returned an error, see sim.log"
	exit 1
fi

if grep -q "Simulation failed" sim.log; then
	echo "FAIL"
	exit 1
fi

if ! grep -q "Simulation passed" sim.log; then
	echo "FAIL: no result line in sim.log"
	exit 1
fi

echo "PASS"
exit 0

/* tb_triangleRaster.sv */
// Testbench for the triangle raster unit
// Reference model of setup, clipping and coverage; queries driven over
// valid/ready and every result compared in order against the model
`timescale 1ns/1ps
`default_nettype none

module tb_triangleRaster import gpuRasterPkg::*; ();

	localparam int TIMEOUT = 2000;	// Cycles per wait loop

	logic clk, rstN, primValid, qValid, resReady;
	logic signed [COORD_W-1:0] x0, y0, x1, y1, x2, y2, qX, qY;
	logic [AREA_W-1:0] daX0, daY0, daX1, daY1;
	logic primReady, setupDone, earlyReject, nullArea, qReady;
	logic resValid, resCovL, resCovR;
	logic signed [COORD_W-1:0] resX, resY;

	int seed = 17882;
	int errors = 0, testErrStart = 0, testsRun = 0, testsOk = 0;
	int cycleCnt = 0;
	int mX[3], mY[3];	// Model vertices
	int bMinX, bMaxX, bMinY, bMaxY;	// Model clipped box
	int qxQ[$], qyQ[$];	// Pending queries
	int recordSel = 0;	// 1 stores coverage, 2 checks overlap against it
	bit covA[0:63][0:63];

	triangleRaster triangleRaster_i (
		.i_clk(clk), .i_rstN(rstN), .i_primValid(primValid), .o_primReady(primReady),
		.i_x0(x0), .i_y0(y0), .i_x1(x1), .i_y1(y1), .i_x2(x2), .i_y2(y2),
		.i_daX0(daX0), .i_daY0(daY0), .i_daX1(daX1), .i_daY1(daY1),
		.o_setupDone(setupDone), .o_earlyReject(earlyReject), .o_nullArea(nullArea),
		.i_qValid(qValid), .o_qReady(qReady), .i_qX(qX), .i_qY(qY),
		.o_resValid(resValid), .o_resCovL(resCovL), .o_resCovR(resCovR),
		.o_resX(resX), .o_resY(resY), .i_resReady(resReady)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;
	always @(posedge clk) cycleCnt <= cycleCnt + 1;	// Index of the last rising edge

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------
	function automatic int topLeft(int yCo, int xCo);
		return (yCo < 0 || (yCo == 0 && xCo < 0)) ? 1 : 0;
	endfunction

	function automatic bit modelCover(int px, int py);
		int e, f, b, nega, c, negd, w0, w1, w2;
		e = mX[2] - mX[1];
		f = mY[1] - mY[2];
		b = mY[2] - mY[0];
		nega = mX[0] - mX[2];
		c = mX[1] - mX[0];
		negd = mY[0] - mY[1];
		w0 = e * (py - mY[1]) + f * (px - mX[1]) - topLeft(f, e);
		w1 = nega * (py - mY[2]) + b * (px - mX[2]) - topLeft(b, nega);
		w2 = c * (py - mY[0]) + negd * (px - mX[0]) - topLeft(negd, c);
		return ((w0 < 0) == (w1 < 0)) && ((w1 < 0) == (w2 < 0)) &&
			px >= bMinX && px <= bMaxX && py >= bMinY && py <= bMaxY;
	endfunction

	function automatic int min3(int a, int b, int c);
		int m;
		m = (a < b) ? a : b;
		return (c < m) ? c : m;
	endfunction

	function automatic int max3(int a, int b, int c);
		int m;
		m = (a > b) ? a : b;
		return (c > m) ? c : m;
	endfunction

	function automatic bit spanBad(int d, int lim);
		return d < -lim || d > lim - 1;
	endfunction

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	task automatic checkVal(string name, int expected, int actual);
		assert (expected == actual) else begin
			$display("Fail at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic abortRun(string what);
		$display("Timeout at %0t while waiting for %s", $time, what);
		$display("Simulation failed");
		$finish;
	endtask

	task automatic finishTest(string name);
		int e;
		e = errors - testErrStart;
		testsRun++;
		if (e == 0)
			testsOk++;
		$display("Test %s: %0d errors", name, e);
		testErrStart = errors;
	endtask

	task automatic randRange(input int lo, input int hi, output int v);
		v = lo + (($random(seed) & 32'h7fff_ffff) % (hi - lo + 1));
	endtask

	// Sends one primitive, checks setup latency and the flags
	task automatic loadPrimitive(int ax, int ay, int bx, int by, int cx, int cy,
		int d0, int d1, int d2, int d3);
		int n, minX, maxX, minY, maxY;
		bit rej, nul;
		mX = '{ax, bx, cx};
		mY = '{ay, by, cy};
		minX = min3(ax, bx, cx);
		maxX = max3(ax, bx, cx);
		minY = min3(ay, by, cy);
		maxY = max3(ay, by, cy);
		bMinX = (minX < d0) ? d0 : minX;
		bMaxX = (maxX > d2) ? d2 : maxX;
		bMinY = (minY < d1) ? d1 : minY;
		bMaxY = (maxY > d3) ? d3 : maxY;
		rej = maxX < d0 || minX > d2 || maxY < d1 || minY > d3 ||
			spanBad(bx - ax, 1024) || spanBad(cx - ax, 1024) ||
			spanBad(by - ay, 512) || spanBad(cy - ay, 512);
		nul = ((cx - ax) * (by - ay) - (cy - ay) * (bx - ax)) == 0;
		@(posedge clk);
		#1;
		primValid = 1'b1;
		{x0, y0, x1, y1, x2, y2} = {ax[11:0], ay[11:0], bx[11:0], by[11:0], cx[11:0], cy[11:0]};
		{daX0, daY0, daX1, daY1} = {d0[9:0], d1[9:0], d2[9:0], d3[9:0]};
		n = 0;
		forever begin
			@(negedge clk);
			if (primReady)
				break;
			if (++n > TIMEOUT)
				abortRun("o_primReady");
		end
		@(posedge clk);	// Transfer edge
		#1;
		primValid = 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!setupDone && n < TIMEOUT);
		if (!setupDone)
			abortRun("o_setupDone");
		else begin
			checkVal("setup latency", 2, n);
			checkVal("o_earlyReject", rej, earlyReject);
			checkVal("o_nullArea", nul, nullArea);
		end
	endtask

	// Pair grid with odd X on odd rows to show bit 0 is ignored
	task automatic addGrid(int xa, int xb, int ya, int yb);
		for (int y = ya; y <= yb; y++)
			for (int x = xa & ~1; x <= xb; x += 2) begin
				qxQ.push_back(x | (y & 1));
				qyQ.push_back(y);
			end
	endtask

	// Sender and receiver run side by side and results are checked in order
	task automatic runQueries(bit randomReady);
		int expX[$], expY[$], expL[$], expR[$], expEdge[$];
		int total, got, idle, n, ex;
		total = qxQ.size();
		fork
			begin
				for (int i = 0; i < total; i++) begin
					@(posedge clk);
					#1;
					qValid = 1'b1;
					qX = qxQ[i];
					qY = qyQ[i];
					n = 0;
					forever begin
						@(negedge clk);
						if (qReady)
							break;
						if (++n > TIMEOUT)
							abortRun("o_qReady");
					end
					ex = qxQ[i] & ~1;
					expX.push_back(ex);
					expY.push_back(qyQ[i]);
					expL.push_back(modelCover(ex, qyQ[i]));
					expR.push_back(modelCover(ex + 1, qyQ[i]));
					expEdge.push_back(cycleCnt + 2);	// Transfer edge plus one
				end
				@(posedge clk);
				#1;
				qValid = 1'b0;
			end
			begin
				got = 0;
				idle = 0;
				while (got < total) begin
					@(posedge clk);
					#1;
					resReady = randomReady ? ($random(seed) & 1) : 1'b1;
					@(negedge clk);
					if (resValid && resReady) begin
						if (expX.size() == 0) begin
							$display("Result at %0t arrived with no query outstanding", $time);
							errors++;
						end else begin
							checkVal("o_resX", expX.pop_front(), resX);
							checkVal("o_resY", expY.pop_front(), resY);
							checkVal("o_resCovL", expL.pop_front(), resCovL);
							checkVal("o_resCovR", expR.pop_front(), resCovR);
							ex = expEdge.pop_front();
							if (!randomReady)
								checkVal("result edge", ex, cycleCnt);
						end
						if (recordSel == 1) begin
							covA[resY][resX] = resCovL;
							covA[resY][resX + 1] = resCovR;
						end else if (recordSel == 2) begin
							assert (!(covA[resY][resX] && resCovL) &&
								!(covA[resY][resX + 1] && resCovR)) else begin
								$display("Fail at %0t: pair %0d,%0d covered by both triangles",
									$time, resX, resY);
								errors++;
							end
						end
						got++;
						idle = 0;
					end else if (++idle > TIMEOUT)
						abortRun("o_resValid");
				end
			end
		join
		@(posedge clk);
		#1;
		resReady = 1'b1;
		repeat (3) begin	// Nothing extra may follow
			@(negedge clk);
			checkVal("o_resValid after drain", 0, resValid);
		end
		qxQ.delete();
		qyQ.delete();
	endtask

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial begin
		int ax, ay, bx, by, cx, cy, d0, d1, d2, d3;
		rstN = 1'b0;
		{primValid, qValid, resReady} = 3'b001;
		{x0, y0, x1, y1, x2, y2, qX, qY} = '0;
		{daX0, daY0, daX1, daY1} = '0;

		repeat (8) begin
			@(negedge clk);
			checkVal("o_resValid in reset", 0, resValid);
			checkVal("o_qReady in reset", 0, qReady);
			checkVal("o_setupDone in reset", 0, setupDone);
			checkVal("o_primReady in reset", 0, primReady);
		end
		@(posedge clk);
		#1;
		rstN = 1'b1;
		@(negedge clk);
		checkVal("o_primReady at release", 0, primReady);
		@(negedge clk);
		checkVal("o_primReady after reset", 1, primReady);
		loadPrimitive(30, 20, 70, 35, 40, 70, 0, 0, 1023, 1023);
		finishTest("reset and setup timing");

		// Both windings, then a clipped case
		loadPrimitive(30, 20, 70, 35, 40, 70, 0, 0, 1023, 1023);
		addGrid(24, 76, 14, 76);
		runQueries(0);
		loadPrimitive(30, 20, 40, 70, 70, 35, 0, 0, 1023, 1023);
		addGrid(24, 76, 14, 76);
		runQueries(0);
		loadPrimitive(30, 20, 70, 35, 40, 70, 40, 30, 60, 50);
		addGrid(34, 66, 24, 56);
		runQueries(0);
		finishTest("winding coverage");

		recordSel = 1;
		loadPrimitive(20, 10, 40, 30, 12, 34, 0, 0, 1023, 1023);
		addGrid(6, 50, 4, 56);
		runQueries(0);
		recordSel = 2;
		loadPrimitive(12, 34, 40, 30, 44, 50, 0, 0, 1023, 1023);
		addGrid(6, 50, 4, 56);
		runQueries(0);
		recordSel = 0;
		finishTest("shared edge");

		loadPrimitive(10, 150, 50, 160, 30, 200, 100, 100, 300, 300);	// Left
		loadPrimitive(400, 150, 450, 160, 420, 200, 100, 100, 300, 300);	// Right
		loadPrimitive(150, 10, 200, 20, 170, 60, 100, 100, 300, 300);	// Above
		loadPrimitive(150, 400, 200, 410, 170, 450, 100, 100, 300, 300);
		loadPrimitive(150, 150, 1300, 160, 200, 200, 100, 100, 300, 300);	// Too wide
		loadPrimitive(150, 150, 250, 160, 200, 250, 100, 100, 300, 300);
		loadPrimitive(120, 120, 140, 140, 160, 160, 100, 100, 300, 300);	// Collinear
		finishTest("reject and zero area");

		loadPrimitive(60, 40, 120, 60, 80, 110, 0, 0, 1023, 1023);
		addGrid(56, 124, 36, 60);
		runQueries(0);
		addGrid(56, 124, 60, 114);
		runQueries(1);
		finishTest("latency and back-pressure");

		for (int t = 0; t < 20; t++) begin
			randRange(100, 400, ax);
			randRange(100, 400, ay);
			randRange(ax - 100, ax + 100, bx);
			randRange(ay - 100, ay + 100, by);
			randRange(ax - 100, ax + 100, cx);
			randRange(ay - 100, ay + 100, cy);
			randRange(0, 200, d0);
			randRange(0, 200, d1);
			randRange(250, 1023, d2);
			randRange(250, 1023, d3);
			loadPrimitive(ax, ay, bx, by, cx, cy, d0, d1, d2, d3);
			repeat (30) begin
				randRange(min3(ax, bx, cx) - 6, max3(ax, bx, cx) + 6, d0);
				randRange(min3(ay, by, cy) - 6, max3(ay, by, cy) + 6, d1);
				qxQ.push_back(d0);
				qyQ.push_back(d1);
			end
			runQueries(t & 1);
		end
		finishTest("random triangles");

		$display("Tests: %0d run, %0d clean, %0d failed checks", testsRun, testsOk, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* triangleRaster.sv */
// Triangle raster top
// Loader, setup, edge evaluator and coverage output in one unit with
// primitive, query and result valid/ready ports
`timescale 1ns/1ps
`default_nettype none

module triangleRaster import gpuRasterPkg::*; (
	input  logic                      i_clk,
	input  logic                      i_rstN,
	// Primitive port
	input  logic                      i_primValid,
	output logic                      o_primReady,
	input  logic signed [COORD_W-1:0] i_x0,
	input  logic signed [COORD_W-1:0] i_y0,
	input  logic signed [COORD_W-1:0] i_x1,
	input  logic signed [COORD_W-1:0] i_y1,
	input  logic signed [COORD_W-1:0] i_x2,
	input  logic signed [COORD_W-1:0] i_y2,
	input  logic [AREA_W-1:0]         i_daX0,
	input  logic [AREA_W-1:0]         i_daY0,
	input  logic [AREA_W-1:0]         i_daX1,
	input  logic [AREA_W-1:0]         i_daY1,
	output logic                      o_setupDone,
	output logic                      o_earlyReject,
	output logic                      o_nullArea,
	// Query port
	input  logic                      i_qValid,
	output logic                      o_qReady,
	input  logic signed [COORD_W-1:0] i_qX,
	input  logic signed [COORD_W-1:0] i_qY,
	// Result port
	output logic                      o_resValid,
	output logic                      o_resCovL,
	output logic                      o_resCovR,
	output logic signed [COORD_W-1:0] o_resX,
	output logic signed [COORD_W-1:0] o_resY,
	input  logic                      i_resReady
);

	logic load, evalValid, stall;
	logic signed [COORD_W-1:0] vx0, vy0, vx1, vy1, vx2, vy2;
	logic signed [COORD_W-1:0] daX0, daY0, daX1, daY1;
	logic signed [COORD_W-1:0] e, f, nega, b, c, negd;
	logic bias0, bias1, bias2;
	logic signed [COORD_W-1:0] boxMinX, boxMaxX, boxMinY, boxMaxY;
	logic signed [EDGE_W-1:0] w0L, w1L, w2L, w0R, w1R, w2R;
	logic signed [COORD_W-1:0] pairX, pairY;

	// --------------------------------------------------
	// Primitive side
	// --------------------------------------------------
	primitiveLoader primitiveLoader_i (
		.i_clk(i_clk), .i_rstN(i_rstN),
		.i_primValid(i_primValid), .o_primReady(o_primReady),
		.i_x0(i_x0), .i_y0(i_y0), .i_x1(i_x1), .i_y1(i_y1), .i_x2(i_x2), .i_y2(i_y2),
		.i_daX0(i_daX0), .i_daY0(i_daY0), .i_daX1(i_daX1), .i_daY1(i_daY1),
		.i_pipeBusy(evalValid | o_resValid),	// No new triangle under queries
		.o_load(load),
		.o_vx0(vx0), .o_vy0(vy0), .o_vx1(vx1), .o_vy1(vy1), .o_vx2(vx2), .o_vy2(vy2),
		.o_daX0(daX0), .o_daY0(daY0), .o_daX1(daX1), .o_daY1(daY1)
	);

	triangleSetup triangleSetup_i (
		.i_clk(i_clk), .i_rstN(i_rstN), .i_load(load),
		.i_vx0(vx0), .i_vy0(vy0), .i_vx1(vx1), .i_vy1(vy1), .i_vx2(vx2), .i_vy2(vy2),
		.i_daX0(daX0), .i_daY0(daY0), .i_daX1(daX1), .i_daY1(daY1),
		.o_setupDone(o_setupDone), .o_earlyReject(o_earlyReject), .o_nullArea(o_nullArea),
		.o_e(e), .o_f(f), .o_nega(nega), .o_b(b), .o_c(c), .o_negd(negd),
		.o_bias0(bias0), .o_bias1(bias1), .o_bias2(bias2),
		.o_boxMinX(boxMinX), .o_boxMaxX(boxMaxX), .o_boxMinY(boxMinY), .o_boxMaxY(boxMaxY)
	);

	// --------------------------------------------------
	// Query side
	// --------------------------------------------------
	edgeEvaluator edgeEvaluator_i (
		.i_clk(i_clk), .i_rstN(i_rstN), .i_setupDone(o_setupDone),
		.i_qValid(i_qValid), .o_qReady(o_qReady), .i_qX(i_qX), .i_qY(i_qY),
		.i_e(e), .i_f(f), .i_nega(nega), .i_b(b), .i_c(c), .i_negd(negd),
		.i_bias0(bias0), .i_bias1(bias1), .i_bias2(bias2),
		.i_vx0(vx0), .i_vy0(vy0), .i_vx1(vx1), .i_vy1(vy1), .i_vx2(vx2), .i_vy2(vy2),
		.i_stall(stall), .o_valid(evalValid),
		.o_w0L(w0L), .o_w1L(w1L), .o_w2L(w2L), .o_w0R(w0R), .o_w1R(w1R), .o_w2R(w2R),
		.o_pairX(pairX), .o_pairY(pairY)
	);

	coverageOutput coverageOutput_i (
		.i_clk(i_clk), .i_rstN(i_rstN), .i_valid(evalValid),
		.i_w0L(w0L), .i_w1L(w1L), .i_w2L(w2L), .i_w0R(w0R), .i_w1R(w1R), .i_w2R(w2R),
		.i_pairX(pairX), .i_pairY(pairY),
		.i_boxMinX(boxMinX), .i_boxMaxX(boxMaxX), .i_boxMinY(boxMinY), .i_boxMaxY(boxMaxY),
		.o_stall(stall), .o_resValid(o_resValid),
		.o_resCovL(o_resCovL), .o_resCovR(o_resCovR), .o_resX(o_resX), .o_resY(o_resY),
		.i_resReady(i_resReady)
	);

endmodule

`default_nettype wire

/* triangleSetup.sv */
// Triangle setup
// Edge coefficients with top-left bias, bounding box clipped to the
// drawing area, early reject and zero-area detection
`timescale 1ns/1ps
`default_nettype none

module triangleSetup import gpuRasterPkg::*; (
	input  logic                      i_clk,
	input  logic                      i_rstN,
	input  logic                      i_load,
	input  logic signed [COORD_W-1:0] i_vx0,
	input  logic signed [COORD_W-1:0] i_vy0,
	input  logic signed [COORD_W-1:0] i_vx1,
	input  logic signed [COORD_W-1:0] i_vy1,
	input  logic signed [COORD_W-1:0] i_vx2,
	input  logic signed [COORD_W-1:0] i_vy2,
	input  logic signed [COORD_W-1:0] i_daX0,
	input  logic signed [COORD_W-1:0] i_daY0,
	input  logic signed [COORD_W-1:0] i_daX1,
	input  logic signed [COORD_W-1:0] i_daY1,
	output logic                      o_setupDone,
	output logic                      o_earlyReject,
	output logic                      o_nullArea,
	output logic signed [COORD_W-1:0] o_e,
	output logic signed [COORD_W-1:0] o_f,
	output logic signed [COORD_W-1:0] o_nega,
	output logic signed [COORD_W-1:0] o_b,
	output logic signed [COORD_W-1:0] o_c,
	output logic signed [COORD_W-1:0] o_negd,
	output logic                      o_bias0,
	output logic                      o_bias1,
	output logic                      o_bias2,
	output logic signed [COORD_W-1:0] o_boxMinX,
	output logic signed [COORD_W-1:0] o_boxMaxX,
	output logic signed [COORD_W-1:0] o_boxMinY,
	output logic signed [COORD_W-1:0] o_boxMaxY
);

	// --------------------------------------------------
	// Differences and span check
	// --------------------------------------------------
	wire signed [DIFF_W-1:0] dX20 = i_vx2 - i_vx0;
	wire signed [DIFF_W-1:0] dY20 = i_vy2 - i_vy0;
	wire signed [DIFF_W-1:0] dX10 = i_vx1 - i_vx0;
	wire signed [DIFF_W-1:0] dY10 = i_vy1 - i_vy0;

	wire [MAX_DX_CHECK_BITS-1:0] topX20 = dX20[DIFF_W-1 -: MAX_DX_CHECK_BITS];
	wire [MAX_DX_CHECK_BITS-1:0] topX10 = dX10[DIFF_W-1 -: MAX_DX_CHECK_BITS];
	wire [MAX_DY_CHECK_BITS-1:0] topY20 = dY20[DIFF_W-1 -: MAX_DY_CHECK_BITS];
	wire [MAX_DY_CHECK_BITS-1:0] topY10 = dY10[DIFF_W-1 -: MAX_DY_CHECK_BITS];

	// Span fits when the top bits are pure sign
	wire spanOk = (&topX20 | ~|topX20) & (&topX10 | ~|topX10) &
		(&topY20 | ~|topY20) & (&topY10 | ~|topY10);

	// Edge coefficients wrap harmlessly once span passes
	wire signed [COORD_W-1:0] aC = dX20[COORD_W-1:0];	// X2-X0
	wire signed [COORD_W-1:0] bC = dY20[COORD_W-1:0];	// Y2-Y0
	wire signed [COORD_W-1:0] cC = dX10[COORD_W-1:0];	// X1-X0
	wire signed [COORD_W-1:0] dC = dY10[COORD_W-1:0];	// Y1-Y0
	wire signed [COORD_W-1:0] eC = i_vx2 - i_vx1;
	wire signed [COORD_W-1:0] fC = i_vy1 - i_vy2;
	wire signed [COORD_W-1:0] negaC = -aC;
	wire signed [COORD_W-1:0] negdC = -dC;

	// Top-left when y coeff negative, or zero with x coeff negative
	wire topLeft0 = fC[COORD_W-1] | ((fC == '0) & eC[COORD_W-1]);
	wire topLeft1 = bC[COORD_W-1] | ((bC == '0) & negaC[COORD_W-1]);
	wire topLeft2 = negdC[COORD_W-1] | ((negdC == '0) & cC[COORD_W-1]);

	// Twice the signed area
	wire signed [DET_W-1:0] det = aC * dC - bC * cC;

	// --------------------------------------------------
	// Bounding box and clip
	// --------------------------------------------------
	wire signed [COORD_W-1:0] minX01 = (i_vx1 < i_vx0) ? i_vx1 : i_vx0;
	wire signed [COORD_W-1:0] maxX01 = (i_vx1 > i_vx0) ? i_vx1 : i_vx0;
	wire signed [COORD_W-1:0] minY01 = (i_vy1 < i_vy0) ? i_vy1 : i_vy0;
	wire signed [COORD_W-1:0] maxY01 = (i_vy1 > i_vy0) ? i_vy1 : i_vy0;
	wire signed [COORD_W-1:0] minX = (i_vx2 < minX01) ? i_vx2 : minX01;
	wire signed [COORD_W-1:0] maxX = (i_vx2 > maxX01) ? i_vx2 : maxX01;
	wire signed [COORD_W-1:0] minY = (i_vy2 < minY01) ? i_vy2 : minY01;
	wire signed [COORD_W-1:0] maxY = (i_vy2 > maxY01) ? i_vy2 : maxY01;

	// Area bounds are inclusive on both sides
	wire outside = (maxX < i_daX0) | (minX > i_daX1) | (maxY < i_daY0) | (minY > i_daY1);

	logic doneQ;	// Results valid since the last load

	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN)
			doneQ <= 1'b0;
		else if (i_load)
			doneQ <= 1'b1;	// Same edge as the result registers
	end

	// Drop straight after the next transfer
	assign o_setupDone = doneQ & ~i_load;

	always_ff @(posedge i_clk) begin
		if (i_load) begin
			o_e <= eC;
			o_f <= fC;
			o_nega <= negaC;
			o_b <= bC;
			o_c <= cC;
			o_negd <= negdC;
			o_bias0 <= topLeft0;
			o_bias1 <= topLeft1;
			o_bias2 <= topLeft2;
			o_boxMinX <= (minX < i_daX0) ? i_daX0 : minX;
			o_boxMaxX <= (maxX > i_daX1) ? i_daX1 : maxX;
			o_boxMinY <= (minY < i_daY0) ? i_daY0 : minY;
			o_boxMaxY <= (maxY > i_daY1) ? i_daY1 : maxY;
			o_earlyReject <= outside | ~spanOk;
			o_nullArea <= (det == '0);
		end
	end

endmodule

`default_nettype wire
